// File: gb_settings.svh
`ifndef GB_SETTINGS_SVH
`define GB_SETTINGS_SVH

// Memory map bounds, inclusive
`define GB_MEM_CART_START 16'h0000
`define GB_MEM_CART_END   16'h7FFF
`define GB_MEM_CRAM_START 16'hA000  // External cart RAM
`define GB_MEM_CRAM_END   16'hBFFF
`define GB_MEM_WRAM_START 16'hC000
`define GB_MEM_WRAM_END   16'hDFFF
`define GB_MEM_ECHO_START 16'hE000  // Mirror of WRAM
`define GB_MEM_ECHO_END   16'hFDFF

// Memory-mapped registers
`define GB_MMIO_DIV  16'hFF04
`define GB_MMIO_TIMA 16'hFF05
`define GB_MMIO_TMA  16'hFF06
`define GB_MMIO_TAC  16'hFF07
`define GB_MMIO_IF   16'hFF0F
`define GB_MMIO_IE   16'hFFFF

// Divider taps picked by TAC[1:0]
`define GB_TAP_0 9  // 4096 Hz
`define GB_TAP_1 3  // 262144 Hz
`define GB_TAP_2 5  // 65536 Hz
`define GB_TAP_3 7  // 16384 Hz

`define GB_JUNK_DATA 8'h00  // Open bus reads as zero

`endif

// File: gb_pkg.sv
package gb_pkg;

    typedef logic [15:0] gb_addr_t;  // CPU address space
    typedef logic [7:0]  gb_data_t;  // One bus byte

    // Single master request, rd and wr are strobes
    typedef struct packed {
        gb_addr_t addr;
        gb_data_t wdata;
        logic     rd;
        logic     wr;
    } gb_bus_req_t;

    // One-hot region select out of the decoder
    typedef struct packed {
        logic wram;    // WRAM and echo
        logic cart;    // ROM and cart RAM
        logic timer;   // DIV/TIMA/TMA/TAC
        logic irq_if;
        logic irq_ie;
        logic junk;    // Nothing mapped
    } gb_region_t;

    // Bit 0 vblank, 1 lcdc, 2 timer, 3 serial, 4 joypad
    typedef logic [4:0] gb_irq_t;

    // Register block to counting core
    typedef struct packed {
        gb_data_t   tma;
        logic       enable;      // TAC[2]
        logic [1:0] tap_sel;     // TAC[1:0]
        logic       div_reset;   // Pulse on DIV write
        logic       tima_wr;     // Pulse on TIMA write
        gb_data_t   tima_wdata;
    } gb_timer_ctrl_t;

endpackage

// File: gb_addr_decode.sv
`timescale 1ns/1ps
`include "gb_settings.svh"

module gb_addr_decode import gb_pkg::*; (
    input  gb_bus_req_t req,
    output gb_region_t  region,
    output logic [12:0] wram_offset  // Byte index into the 8 KiB array
);

    logic     in_wram;
    logic     in_echo;
    logic     in_rom;
    logic     in_cram;
    gb_addr_t off_long;  // Full-width offset before truncation

    //////////////////////////////////////////////////
    // Range compares
    //////////////////////////////////////////////////
    assign in_wram = (req.addr >= `GB_MEM_WRAM_START) && (req.addr <= `GB_MEM_WRAM_END);
    assign in_echo = (req.addr >= `GB_MEM_ECHO_START) && (req.addr <= `GB_MEM_ECHO_END);
    assign in_rom  = (req.addr >= `GB_MEM_CART_START) && (req.addr <= `GB_MEM_CART_END);
    assign in_cram = (req.addr >= `GB_MEM_CRAM_START) && (req.addr <= `GB_MEM_CRAM_END);

    always_comb begin
        region        = '0;
        region.wram   = in_wram | in_echo;  // Echo aliases WRAM
        region.cart   = in_rom | in_cram;
        region.timer  = (req.addr == `GB_MMIO_DIV)  ||
                        (req.addr == `GB_MMIO_TIMA) ||
                        (req.addr == `GB_MMIO_TMA)  ||
                        (req.addr == `GB_MMIO_TAC);
        region.irq_if = (req.addr == `GB_MMIO_IF);
        region.irq_ie = (req.addr == `GB_MMIO_IE);
        // Fallback when nothing else claims the address
        region.junk   = ~(region.wram | region.cart | region.timer |
                          region.irq_if | region.irq_ie);
    end

    //////////////////////////////////////////////////
    // WRAM offset
    //////////////////////////////////////////////////
    always_comb begin
        if (in_echo) begin
            off_long = req.addr - `GB_MEM_ECHO_START;  // E000 lands on C000
        end else begin
            off_long = req.addr - `GB_MEM_WRAM_START;
        end
    end

    assign wram_offset = off_long[12:0];  // Don't care outside WRAM

endmodule

// File: gb_wram.sv
`timescale 1ns/1ps

module gb_wram import gb_pkg::*; (
    input  logic        clk,
    input  gb_bus_req_t req,
    input  logic        sel,     // Region hit from decoder
    input  logic [12:0] offset,
    output gb_data_t    rdata    // Valid the cycle after rd
);

    // 8 KiB single port array
    gb_data_t mem [0:8191];

    // Write port
    always_ff @(posedge clk) begin
        if (sel && req.wr) begin
            mem[offset] <= req.wdata;
        end
    end

    // Read side registered on every edge
    // so the byte lines up with rvalid at the top
    always_ff @(posedge clk) begin
        rdata <= mem[offset];  // Old data on a same-cycle write
    end

endmodule

// File: gb_timer_regs.sv
`timescale 1ns/1ps
`include "gb_settings.svh"

module gb_timer_regs import gb_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  gb_bus_req_t    req,
    input  logic           sel,    // Address is one of the four timer regs
    input  gb_data_t       div,    // Upper divider byte from core
    input  gb_data_t       tima,   // Live counter from core
    output gb_timer_ctrl_t ctrl,
    output gb_data_t       rdata   // Registered read byte
);

    gb_data_t   tma_q;
    logic [2:0] tac_q;  // enable, tap_sel
    logic       wr_hit;

    assign wr_hit = sel & req.wr;

    //////////////////////////////////////////////////
    // TMA and TAC
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tma_q <= '0;
            tac_q <= '0;
        end else begin
            if (wr_hit && (req.addr == `GB_MMIO_TMA))
                tma_q <= req.wdata;
            if (wr_hit && (req.addr == `GB_MMIO_TAC))
                tac_q <= req.wdata[2:0];  // Upper bits not stored
        end
    end

    // Control out to the counting core
    always_comb begin
        ctrl            = '0;
        ctrl.tma        = tma_q;
        ctrl.enable     = tac_q[2];
        ctrl.tap_sel    = tac_q[1:0];
        ctrl.div_reset  = wr_hit && (req.addr == `GB_MMIO_DIV);   // Any value clears
        ctrl.tima_wr    = wr_hit && (req.addr == `GB_MMIO_TIMA);
        ctrl.tima_wdata = req.wdata;
    end

    // Read mux on addr[1:0], FF04..FF07
    always_ff @(posedge clk) begin
        if (sel && req.rd) begin
            case (req.addr[1:0])
                2'd0:    rdata <= div;
                2'd1:    rdata <= tima;
                2'd2:    rdata <= tma_q;
                default: rdata <= {5'b11111, tac_q};  // Unused TAC bits read 1
            endcase
        end
    end

endmodule

// File: gb_timer_core.sv
`timescale 1ns/1ps
`include "gb_settings.svh"

module gb_timer_core import gb_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  gb_timer_ctrl_t ctrl,
    output gb_data_t       div,
    output gb_data_t       tima,
    output logic           timer_req  // One cycle, with the reload
);

    logic [15:0] div_cnt;
    logic        tap_bit;
    logic        tap_q;   // Tap bit one cycle back
    logic        tick;    // Falling edge of the tap

    // Free running divider, DIV write clears it
    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.div_reset)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 16'd1;
    end

    assign div = div_cnt[15:8];  // CPU sees the top byte

    //////////////////////////////////////////////////
    // Tap select and edge detect
    //////////////////////////////////////////////////
    always_comb begin
        case (ctrl.tap_sel)
            2'd0:    tap_bit = div_cnt[`GB_TAP_0];
            2'd1:    tap_bit = div_cnt[`GB_TAP_1];
            2'd2:    tap_bit = div_cnt[`GB_TAP_2];
            default: tap_bit = div_cnt[`GB_TAP_3];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) tap_q <= 1'b0;
        else        tap_q <= tap_bit;
    end

    assign tick = ctrl.enable & tap_q & ~tap_bit;

    // TIMA counter, bus write has priority
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tima      <= '0;
            timer_req <= 1'b0;
        end else begin
            timer_req <= 1'b0;
            if (ctrl.tima_wr) begin
                tima <= ctrl.tima_wdata;
            end else if (tick) begin
                if (tima == 8'hFF) begin
                    tima      <= ctrl.tma;  // Overflow reload
                    timer_req <= 1'b1;
                end else begin
                    tima <= tima + 8'd1;
                end
            end
        end
    end

endmodule

// File: gb_irq_ctrl.sv
`timescale 1ns/1ps

module gb_irq_ctrl import gb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  gb_bus_req_t req,
    input  logic        sel_if,
    input  logic        sel_ie,
    input  gb_irq_t     irq_req,    // Level at the edge sets IF
    output gb_irq_t     if_q,
    output gb_irq_t     ie_q,
    output logic        irq_pending
);

    logic if_wr;
    logic ie_wr;

    assign if_wr = sel_if & req.wr;
    assign ie_wr = sel_ie & req.wr;

    //////////////////////////////////////////////////
    // Interrupt flag
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_q <= '0;
        end else if (if_wr) begin
            // Replace, but a request in the same cycle is not lost
            if_q <= req.wdata[4:0] | irq_req;
        end else begin
            if_q <= if_q | irq_req;  // Sticky until software clears
        end
    end

    // Interrupt enable
    always_ff @(posedge clk) begin
        if (!rst_n)     ie_q <= '0;
        else if (ie_wr) ie_q <= req.wdata[4:0];
    end

    assign irq_pending = |(if_q & ie_q);  // Straight from the flops

endmodule

// File: gb_soc_bus.sv
`timescale 1ns/1ps
`include "gb_settings.svh"

module gb_soc_bus import gb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  gb_bus_req_t req,
    output gb_data_t    rdata,
    output logic        rvalid,
    input  gb_irq_t     ext_irq_req,  // Bit 2 comes from the timer instead
    output logic        irq_pending,
    output gb_addr_t    cart_addr,
    output gb_data_t    cart_wdata,
    output logic        cart_wr,
    output logic        cart_rd,
    input  gb_data_t    cart_din
);

    gb_region_t     region;
    gb_region_t     rd_region;  // Region of the last read
    logic [12:0]    wram_offset;
    gb_data_t       wram_rdata;
    gb_data_t       timer_rdata;
    gb_data_t       cart_q;     // Cart byte caught at the rd edge
    gb_timer_ctrl_t timer_ctrl;
    gb_data_t       div;
    gb_data_t       tima;
    logic           timer_req;
    gb_irq_t        irq_vec;
    gb_irq_t        if_q;
    gb_irq_t        ie_q;

    gb_addr_decode i_decode (.req(req), .region(region), .wram_offset(wram_offset));

    gb_wram i_wram (
        .clk(clk), .req(req), .sel(region.wram), .offset(wram_offset), .rdata(wram_rdata)
    );

    //////////////////////////////////////////////////
    // Timer and interrupts
    //////////////////////////////////////////////////
    gb_timer_regs i_timer_regs (
        .clk(clk), .rst_n(rst_n), .req(req), .sel(region.timer),
        .div(div), .tima(tima), .ctrl(timer_ctrl), .rdata(timer_rdata)
    );

    gb_timer_core i_timer_core (
        .clk(clk), .rst_n(rst_n), .ctrl(timer_ctrl),
        .div(div), .tima(tima), .timer_req(timer_req)
    );

    // Timer owns bit 2, the rest pass through
    assign irq_vec = {ext_irq_req[4:3], timer_req, ext_irq_req[1:0]};

    gb_irq_ctrl i_irq (
        .clk(clk), .rst_n(rst_n), .req(req), .sel_if(region.irq_if), .sel_ie(region.irq_ie),
        .irq_req(irq_vec), .if_q(if_q), .ie_q(ie_q), .irq_pending(irq_pending)
    );

    // Cartridge pins track the bus directly
    assign cart_addr  = req.addr;
    assign cart_wdata = req.wdata;
    assign cart_wr    = req.wr & region.cart;
    assign cart_rd    = req.rd & region.cart;

    //////////////////////////////////////////////////
    // Read return path
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid    <= 1'b0;
            rd_region <= '0;
        end else begin
            rvalid <= req.rd;  // No wait states
            if (req.rd)
                rd_region <= region;
        end
    end

    always_ff @(posedge clk) begin
        if (cart_rd)
            cart_q <= cart_din;
    end

    // rd_region is one-hot, pick the owner
    always_comb begin
        unique case (1'b1)
            rd_region.wram:   rdata = wram_rdata;
            rd_region.cart:   rdata = cart_q;
            rd_region.timer:  rdata = timer_rdata;
            rd_region.irq_if: rdata = {3'b000, if_q};
            rd_region.irq_ie: rdata = {3'b000, ie_q};
            rd_region.junk:   rdata = `GB_JUNK_DATA;
            default:          rdata = `GB_JUNK_DATA;  // Only before first read
        endcase
    end

endmodule

// File: gb_assert.sv
`timescale 1ns/1ps

module gb_assert import gb_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input gb_bus_req_t req,
    input logic        rvalid,
    input logic        cart_wr,
    input logic        cart_rd,
    input gb_irq_t     ext_irq_req,
    input logic        irq_pending,
    input gb_irq_t     if_q,
    input gb_irq_t     ie_q
);

    //////////////////////////////////////////////////
    // Bus protocol
    //////////////////////////////////////////////////
    a_rvalid_lag: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid == $past(req.rd))  // Exactly one cycle after rd
        else $error("rvalid does not follow rd by one cycle");

    a_strobes: assert property (@(posedge clk) !(req.rd && req.wr))
        else $error("rd and wr high together");

    a_cart_pins: assert property (@(posedge clk) !(cart_wr && cart_rd))
        else $error("cart_wr and cart_rd high together");

    // Enabled outside request shows on pending next cycle, bit 2 is the timer's
    a_pending: assert property (@(posedge clk) disable iff (!rst_n)
        (!req.wr && |(ext_irq_req & ie_q & 5'b11011)) |=> irq_pending)
        else $error("enabled outside request did not raise irq_pending");

endmodule

bind gb_soc_bus gb_assert i_assert (
    .clk(clk), .rst_n(rst_n), .req(req), .rvalid(rvalid),
    .cart_wr(cart_wr), .cart_rd(cart_rd), .ext_irq_req(ext_irq_req),
    .irq_pending(irq_pending), .if_q(if_q), .ie_q(ie_q)
);

// File: gb_tb.sv
`timescale 1ns/1ps
`include "gb_settings.svh"

module gb_tb import gb_pkg::*; ();

    logic        clk;
    logic        rst_n;
    gb_bus_req_t req;
    gb_data_t    rdata;
    logic        rvalid;
    gb_irq_t     ext_irq_req;
    logic        irq_pending;
    gb_addr_t    cart_addr;
    gb_data_t    cart_wdata;
    logic        cart_wr;
    logic        cart_rd;
    gb_data_t    cart_din;
    integer      seed;
    logic [31:0] rnd;

    gb_soc_bus i_dut (
        .clk(clk), .rst_n(rst_n), .req(req), .rdata(rdata), .rvalid(rvalid),
        .ext_irq_req(ext_irq_req), .irq_pending(irq_pending),
        .cart_addr(cart_addr), .cart_wdata(cart_wdata),
        .cart_wr(cart_wr), .cart_rd(cart_rd), .cart_din(cart_din)
    );

    always #2 clk = ~clk;  // 4 ns period

    //////////////////////////////////////////////////
    // Failure and compare tasks
    //////////////////////////////////////////////////
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input gb_data_t got, input gb_data_t exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_irq(input string name, input gb_irq_t got, input gb_irq_t exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input gb_addr_t got, input gb_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Bus master
    //////////////////////////////////////////////////
    task automatic bus_write(input gb_addr_t addr, input gb_data_t data);
        @(negedge clk);
        req.addr  = addr;
        req.wdata = data;
        req.wr    = 1'b1;
        @(negedge clk);
        req.wr = 1'b0;  // Single-cycle strobe
    endtask

    task automatic wait_rvalid(output gb_data_t data);
        int n;
        n = 0;
        while (!rvalid) begin
            if (n == 8)
                abort_run("Timeout: no rvalid after a read strobe");
            @(negedge clk);
            n++;
        end
        data = rdata;  // Registered, stable at the falling edge
    endtask

    task automatic bus_read(input gb_addr_t addr, output gb_data_t data);
        @(negedge clk);
        req.addr = addr;
        req.rd   = 1'b1;
        @(negedge clk);
        req.rd = 1'b0;
        wait_rvalid(data);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic wram_rw();
        gb_addr_t a;
        gb_data_t d;
        gb_data_t got;
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            a   = `GB_MEM_WRAM_START | {3'b000, rnd[12:0]};
            d   = rnd[23:16];
            bus_write(a, d);
            bus_read(a, got);
            check_data("wram rdata", got, d);
        end
        rnd = $random(seed);
        d   = rnd[7:0];
        bus_write(`GB_MEM_ECHO_START | {4'h0, rnd[19:8]}, d);  // Echo to WRAM
        bus_read(`GB_MEM_WRAM_START | {4'h0, rnd[19:8]}, got);
        check_data("echo to wram rdata", got, d);
        bus_write(`GB_MEM_WRAM_START | {4'h0, rnd[31:20]}, ~d);  // And back
        bus_read(`GB_MEM_ECHO_START | {4'h0, rnd[31:20]}, got);
        check_data("wram to echo rdata", got, ~d);
    endtask

    task automatic cart_access();
        gb_data_t d;
        gb_data_t got;
        rnd = $random(seed);
        d   = rnd[7:0];
        @(negedge clk);
        req.addr  = 16'hA010;  // Cart RAM window
        req.wdata = d;
        req.wr    = 1'b1;
        #1;
        check_addr("cart_addr", cart_addr, 16'hA010);
        check_data("cart_wdata", cart_wdata, d);
        check_bit("cart_wr", cart_wr, 1'b1);
        check_bit("cart_rd", cart_rd, 1'b0);
        @(negedge clk);
        req.wr   = 1'b0;
        req.addr = 16'h2345;  // ROM space
        req.rd   = 1'b1;
        cart_din = ~d;
        #1;
        check_bit("cart_rd", cart_rd, 1'b1);
        check_bit("cart_wr", cart_wr, 1'b0);
        @(negedge clk);
        req.rd   = 1'b0;
        cart_din = d;  // Must not leak into the result
        wait_rvalid(got);
        check_data("cart rdata", got, ~d);
    endtask

    task automatic timer_registers();
        gb_data_t d;
        gb_data_t got;
        int       n;
        rnd = $random(seed);
        d   = rnd[7:0];
        bus_write(`GB_MMIO_TMA, d);
        bus_read(`GB_MMIO_TMA, got);
        check_data("tma", got, d);
        bus_write(`GB_MMIO_TAC, 8'h05);
        bus_read(`GB_MMIO_TAC, got);
        check_data("tac", got, 8'hFD);  // Upper five bits read as ones
        n = 0;
        bus_read(`GB_MMIO_DIV, got);
        while (got < 8'd2) begin  // Let DIV climb so the clear shows
            if (n == 600)
                abort_run("Timeout: DIV did not count up from reset");
            bus_read(`GB_MMIO_DIV, got);
            n++;
        end
        bus_write(`GB_MMIO_DIV, d);
        n = 0;
        bus_read(`GB_MMIO_DIV, got);
        while (got >= 8'd2) begin
            if (n == 4)
                abort_run("Timeout: DIV did not restart after a write");
            bus_read(`GB_MMIO_DIV, got);
            n++;
        end
        bus_write(`GB_MMIO_TIMA, 8'h00);
        bus_write(`GB_MMIO_TAC, 8'h07);  // Enable, tap on divider bit 7
        n = 0;
        bus_read(`GB_MMIO_TIMA, got);
        while (got == 8'h00) begin
            if (n == 400)
                abort_run("Timeout: TIMA did not count with the timer enabled");
            bus_read(`GB_MMIO_TIMA, got);
            n++;
        end
    endtask

    task automatic timer_overflow();
        gb_data_t got;
        int       n;
        bus_write(`GB_MMIO_TAC, 8'h00);   // Stop counting first
        bus_write(`GB_MMIO_TMA, 8'h5A);
        bus_write(`GB_MMIO_IF, 8'h00);
        bus_write(`GB_MMIO_TIMA, 8'hFE);
        bus_write(`GB_MMIO_TAC, 8'h05);   // Fast tap, bit 3
        n = 0;
        bus_read(`GB_MMIO_IF, got);
        while (!got[2]) begin
            if (n == 100)
                abort_run("Timeout: timer interrupt flag never set");
            bus_read(`GB_MMIO_IF, got);
            n++;
        end
        bus_read(`GB_MMIO_TIMA, got);
        if (got < 8'h5A || got > 8'h5B)
            abort_run($sformatf("Error: tima got %h expected 5a or 5b", got));
        bus_write(`GB_MMIO_TAC, 8'h00);
        bus_write(`GB_MMIO_IF, 8'h00);
        bus_read(`GB_MMIO_IF, got);
        check_irq("if", got[4:0], 5'h00);
    endtask

    task automatic pulse_irq(input gb_irq_t bits);
        @(negedge clk);
        ext_irq_req = bits;
        @(negedge clk);
        ext_irq_req = '0;
    endtask

    task automatic irq_flags();
        gb_irq_t  if_exp;
        gb_irq_t  ie_exp;
        gb_data_t got;
        if_exp = 5'h00;
        pulse_irq(5'b00001);  // vblank
        if_exp = if_exp | 5'b00001;
        bus_read(`GB_MMIO_IF, got);
        check_irq("if", got[4:0], if_exp);
        pulse_irq(5'b11000);  // serial and joypad
        if_exp = if_exp | 5'b11000;
        pulse_irq(5'b00100);  // Timer bit belongs to the timer
        bus_read(`GB_MMIO_IF, got);
        check_irq("if", got[4:0], if_exp);
        check_data("if upper bits", got & 8'hE0, 8'h00);
        bus_write(`GB_MMIO_IE, 8'hE2);  // Only lcdc enabled, no flag there
        check_bit("irq_pending", irq_pending, 1'b0);
        bus_write(`GB_MMIO_IE, 8'hFF);
        ie_exp = 5'h1F;
        bus_read(`GB_MMIO_IE, got);
        check_data("ie", got, {3'b000, ie_exp});
        check_bit("irq_pending", irq_pending, 1'b1);
        bus_write(`GB_MMIO_IF, 8'h06);  // Replace, not OR
        if_exp = 5'h06;
        bus_read(`GB_MMIO_IF, got);
        check_irq("if", got[4:0], if_exp);
        bus_write(`GB_MMIO_IF, 8'h00);
        check_bit("irq_pending", irq_pending, 1'b0);
        pulse_irq(5'b01000);  // Serial with IE set
        check_bit("irq_pending", irq_pending, 1'b1);
        bus_read(`GB_MMIO_IF, got);
        check_irq("if", got[4:0], 5'b01000);
        bus_read(16'hFF80, got);  // HRAM not in this subsystem
        check_data("unmapped rdata", got, 8'h00);
    endtask

    initial begin
        seed        = 32'h769ca812;
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = '0;
        ext_irq_req = '0;
        cart_din    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wram_rw();
        cart_access();
        timer_registers();
        timer_overflow();
        irq_flags();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: src.f
+incdir+.
gb_pkg.sv
gb_addr_decode.sv
gb_wram.sv
gb_timer_regs.sv
gb_timer_core.sv
gb_irq_ctrl.sv
gb_soc_bus.sv
gb_assert.sv
gb_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench, exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module gb_tb \
    -f src.f \
    -o gb_sim

./obj_dir/gb_sim
